// File: common/audio_pkg.sv
package audio_pkg;

	// default widths, overridden through the top-level parameters
	parameter int SAMPLE_W = 16;
	parameter int ADDR_W   = 20;

	// one signed pcm word
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// engine modes as seen on o_mode
	typedef enum logic [2:0] {
		MODE_IDLE,       // nothing recorded yet
		MODE_REC,
		MODE_REC_PAUSE,
		MODE_WAIT,       // recording present, not playing
		MODE_PLAY,
		MODE_PLAY_PAUSE
	} mode_e;

	// controller to playback datapath
	typedef enum logic [1:0] {
		CMD_HOLD,
		CMD_RUN,
		CMD_RESET
	} play_cmd_e;

	typedef struct packed {
		logic [2:0] speed_m1; // factor minus one
		logic       fast;
		logic       inte;     // linear interpolation in slow mode
	} play_cfg_t;

	// request toward the external async sram
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		sample_t           wdata;
		logic              we_n;
	} sram_req_t;

endpackage

// File: source/audio_ctrl.sv
module audio_ctrl
	import audio_pkg::*;
#(
	parameter int P_SAMPLE_W = SAMPLE_W,
	parameter int P_ADDR_W   = ADDR_W
) (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_rec,
	input  logic                  i_play,
	input  logic                  i_pause,
	input  logic                  i_stop,
	input  logic                  i_wr_stb,
	input  logic [P_ADDR_W-1:0]   i_wr_addr,
	input  logic [P_SAMPLE_W-1:0] i_wr_data,
	input  logic [P_ADDR_W-1:0]   i_rd_addr,
	input  logic                  i_play_end,
	output logic                  o_rec_en,
	output play_cmd_e             o_play_cmd,
	output logic [P_ADDR_W:0]     o_end_addr,
	output sram_req_t             o_sram,
	output mode_e                 o_mode
);

	mode_e               mode_q;
	mode_e               mode_d;
	logic [P_ADDR_W:0]   end_addr_q;   // number of stored samples
	logic [P_ADDR_W:0]   end_addr_d;
	logic [P_ADDR_W-1:0] rec_base_q;
	logic [P_ADDR_W-1:0] rec_base_d;
	logic [P_ADDR_W-1:0] rec_addr;
	logic                recording;
	logic                mem_full;

	// the recorder pointer runs on across recordings, so every new
	// recording is rebased to start at address 0
	assign rec_addr   = i_wr_addr - rec_base_q;
	assign recording  = (mode_q == MODE_REC) || (mode_q == MODE_REC_PAUSE);
	assign mem_full   = i_wr_stb && (&rec_addr); // last word just written
	assign o_rec_en   = (mode_q == MODE_REC);
	assign o_end_addr = end_addr_q;
	assign o_mode     = mode_q;

	always_comb begin
		mode_d     = mode_q;
		end_addr_d = end_addr_q;
		rec_base_d = rec_base_q;
		o_play_cmd = CMD_HOLD;
		case (mode_q)
			MODE_IDLE, MODE_WAIT: begin
				if (i_rec) begin
					mode_d     = MODE_REC;
					end_addr_d = '0;
					rec_base_d = i_wr_addr;
				end else if (i_play && (mode_q == MODE_WAIT)) begin
					mode_d = MODE_PLAY;
				end
			end
			MODE_REC, MODE_REC_PAUSE: begin
				if (i_wr_stb)
					end_addr_d = {1'b0, rec_addr} + 1'b1;
				if (i_stop || mem_full)
					mode_d = MODE_WAIT;
				else if (i_pause)
					mode_d = (mode_q == MODE_REC) ? MODE_REC_PAUSE : MODE_REC;
			end
			MODE_PLAY, MODE_PLAY_PAUSE: begin
				if (mode_q == MODE_PLAY)
					o_play_cmd = CMD_RUN;
				if (i_stop || i_play_end) begin
					o_play_cmd = CMD_RESET; // rewind for the next play
					mode_d     = MODE_WAIT;
				end else if (i_pause) begin
					mode_d = (mode_q == MODE_PLAY) ? MODE_PLAY_PAUSE : MODE_PLAY;
				end
			end
			default: mode_d = MODE_IDLE;
		endcase
	end

	// sram bus owner
	always_comb begin
		if (recording) begin
			o_sram.addr  = rec_addr;
			o_sram.wdata = i_wr_data;
			o_sram.we_n  = ~i_wr_stb;
		end else begin
			o_sram.addr  = i_rd_addr;
			o_sram.wdata = '0;
			o_sram.we_n  = 1'b1;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mode_q     <= MODE_IDLE;
			end_addr_q <= '0;
			rec_base_q <= '0;
		end else begin
			mode_q     <= mode_d;
			end_addr_q <= end_addr_d;
			rec_base_q <= rec_base_d;
		end
	end

endmodule

// File: recorder/i2s_rx.sv
module i2s_rx
	import audio_pkg::*;
#(
	parameter int P_SAMPLE_W = SAMPLE_W,
	parameter int P_ADDR_W   = ADDR_W
) (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_en,
	input  logic                  i_adcdat,
	input  logic                  i_adclrck,
	output logic                  o_wr_stb,
	output logic [P_ADDR_W-1:0]   o_wr_addr,
	output logic [P_SAMPLE_W-1:0] o_wr_data
);

	localparam int CNT_W = $clog2(P_SAMPLE_W);

	typedef enum logic [1:0] {
		RX_WAIT,   // look for the left half-frame
		RX_SHIFT,
		RX_STORE
	} rx_state_e;

	rx_state_e             state_q;
	logic                  lrc_q;
	logic                  lrc_fall;
	logic                  capture;
	logic [CNT_W-1:0]      bit_cnt_q;
	logic [P_SAMPLE_W-1:0] shift_q;
	logic [P_ADDR_W-1:0]   addr_q;

	assign lrc_fall  = lrc_q & ~i_adclrck;
	assign capture   = i_en && (((state_q == RX_WAIT) && lrc_fall) || (state_q == RX_SHIFT));
	assign o_wr_stb  = (state_q == RX_STORE);
	assign o_wr_addr = addr_q;
	assign o_wr_data = shift_q;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q   <= RX_WAIT;
			lrc_q     <= 1'b0;
			bit_cnt_q <= '0;
			addr_q    <= '0;
		end else begin
			lrc_q <= i_adclrck;
			case (state_q)
				RX_WAIT: begin
					if (i_en && lrc_fall) begin
						state_q   <= RX_SHIFT;
						bit_cnt_q <= CNT_W'(1); // msb taken on the fall
					end
				end
				RX_SHIFT: begin
					if (!i_en) begin
						state_q <= RX_WAIT; // partial word dropped
					end else begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
						if (bit_cnt_q == CNT_W'(P_SAMPLE_W - 1))
							state_q <= RX_STORE;
					end
				end
				RX_STORE: begin
					addr_q  <= addr_q + 1'b1; // wraps at full memory
					state_q <= RX_WAIT;
				end
				default: state_q <= RX_WAIT;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (capture)
			shift_q <= {shift_q[P_SAMPLE_W-2:0], i_adcdat};
	end

endmodule

// File: player/play_dsp.sv
module play_dsp
	import audio_pkg::*;
#(
	parameter int P_SAMPLE_W = SAMPLE_W,
	parameter int P_ADDR_W   = ADDR_W
) (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  play_cmd_e           i_cmd,
	input  play_cfg_t           i_cfg,
	input  logic [P_ADDR_W:0]   i_end_addr,
	input  logic                i_daclrck,
	input  sample_t             i_rdata,
	output logic [P_ADDR_W-1:0] o_rd_addr,
	output sample_t             o_sample,
	output logic                o_player_en,
	output logic                o_end
);

	logic                        lrc_q;
	logic                        lrc_rise;
	logic [P_ADDR_W:0]           addr_q;   // one spare bit so a skip never wraps
	logic [2:0]                  phase_q;  // repeat index in slow mode
	logic [3:0]                  factor;
	sample_t                     prev_q;
	logic signed [P_SAMPLE_W:0]   diff;
	logic signed [P_SAMPLE_W+4:0] scaled;
	logic signed [P_SAMPLE_W+4:0] frac;
	sample_t                     interp;

	assign lrc_rise  = i_daclrck & ~lrc_q;
	assign factor    = {1'b0, i_cfg.speed_m1} + 4'd1;
	assign o_rd_addr = addr_q[P_ADDR_W-1:0];

	// prev + (next - prev) * c / s, divide truncates toward zero
	always_comb begin
		diff   = i_rdata - prev_q;
		scaled = diff * $signed({1'b0, phase_q});
		frac   = scaled / $signed({1'b0, factor});
		interp = prev_q + frac[P_SAMPLE_W-1:0];
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lrc_q       <= 1'b0;
			addr_q      <= '0;
			phase_q     <= '0;
			o_sample    <= '0;
			o_player_en <= 1'b0;
			o_end       <= 1'b0;
		end else begin
			lrc_q <= i_daclrck;
			case (i_cmd)
				CMD_RESET: begin
					addr_q      <= '0;
					phase_q     <= '0;
					o_player_en <= 1'b0;
					o_end       <= 1'b0;
				end
				CMD_RUN: begin
					if (lrc_rise) begin
						if (addr_q >= i_end_addr) begin
							o_end <= 1'b1; // last word already shifted out
						end else if (i_cfg.fast) begin
							o_player_en <= 1'b1;
							o_sample    <= i_rdata;
							addr_q      <= addr_q + factor;
							phase_q     <= '0;
						end else begin
							o_player_en <= 1'b1;
							phase_q     <= (phase_q == i_cfg.speed_m1) ? 3'd0 : phase_q + 3'd1;
							if (phase_q == 3'd0) begin
								o_sample <= i_rdata;
								addr_q   <= addr_q + 1'b1; // rdata becomes the next sample
							end else begin
								o_sample <= i_cfg.inte ? interp : prev_q;
							end
						end
					end
				end
				default: o_player_en <= 1'b0;
			endcase
		end
	end

	// stored sample kept for repeats
	always_ff @(posedge i_clk) begin
		if ((i_cmd == CMD_RUN) && lrc_rise && !i_cfg.fast && (phase_q == 3'd0))
			prev_q <= i_rdata;
	end

endmodule

// File: player/i2s_tx.sv
module i2s_tx
	import audio_pkg::*;
#(
	parameter int P_SAMPLE_W = SAMPLE_W
) (
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  logic    i_en,
	input  logic    i_daclrck,
	input  sample_t i_sample,
	output logic    o_dacdat
);

	localparam int CNT_W = $clog2(P_SAMPLE_W) + 1;

	logic                  lrc_q;
	logic                  lrc_fall;
	logic                  busy;
	logic [CNT_W-1:0]      bits_left_q;
	logic [P_SAMPLE_W-1:0] shift_q;

	assign lrc_fall = lrc_q & ~i_daclrck;
	assign busy     = (bits_left_q != '0);
	assign o_dacdat = i_en && busy && shift_q[P_SAMPLE_W-1]; // msb first

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lrc_q       <= 1'b0;
			bits_left_q <= '0;
		end else begin
			lrc_q <= i_daclrck;
			if (!i_en)
				bits_left_q <= '0;
			else if (lrc_fall)
				bits_left_q <= CNT_W'(P_SAMPLE_W); // left half starts
			else if (busy)
				bits_left_q <= bits_left_q - 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_en && lrc_fall)
			shift_q <= i_sample;
		else if (busy)
			shift_q <= {shift_q[P_SAMPLE_W-2:0], 1'b0};
	end

endmodule

// File: source/audio_top.sv
module audio_top
	import audio_pkg::*;
#(
	parameter int P_SAMPLE_W = SAMPLE_W,
	parameter int P_ADDR_W   = ADDR_W
) (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_rec,
	input  logic      i_play,
	input  logic      i_pause,
	input  logic      i_stop,
	input  logic [3:0] i_speed,   // 0 to 8
	input  logic      i_fast,
	input  logic      i_inte,
	input  logic      i_adcdat,
	input  logic      i_adclrck,
	input  logic      i_daclrck,
	input  sample_t   i_sram_rdata,
	output sram_req_t o_sram,
	output logic      o_dacdat,
	output mode_e     o_mode
);

	logic                  rec_en;
	logic                  wr_stb;
	logic [P_ADDR_W-1:0]   wr_addr;
	logic [P_SAMPLE_W-1:0] wr_data;
	logic [P_ADDR_W-1:0]   rd_addr;
	logic [P_ADDR_W:0]     end_addr;
	logic                  play_end;
	logic                  player_en;
	play_cmd_e             play_cmd;
	play_cfg_t             play_cfg;
	sample_t               play_sample;

	// speed 0 and 1 both mean real time
	always_comb begin
		play_cfg.fast = i_fast;
		play_cfg.inte = i_inte;
		if (i_speed <= 4'd1)
			play_cfg.speed_m1 = 3'd0;
		else if (i_speed >= 4'd8)
			play_cfg.speed_m1 = 3'd7;
		else
			play_cfg.speed_m1 = 3'(i_speed - 4'd1);
	end

	audio_ctrl #(
		.P_SAMPLE_W (P_SAMPLE_W),
		.P_ADDR_W   (P_ADDR_W)
	) u_ctrl (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_rec      (i_rec),
		.i_play     (i_play),
		.i_pause    (i_pause),
		.i_stop     (i_stop),
		.i_wr_stb   (wr_stb),
		.i_wr_addr  (wr_addr),
		.i_wr_data  (wr_data),
		.i_rd_addr  (rd_addr),
		.i_play_end (play_end),
		.o_rec_en   (rec_en),
		.o_play_cmd (play_cmd),
		.o_end_addr (end_addr),
		.o_sram     (o_sram),
		.o_mode     (o_mode)
	);

	i2s_rx #(
		.P_SAMPLE_W (P_SAMPLE_W),
		.P_ADDR_W   (P_ADDR_W)
	) u_rx (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_en      (rec_en),
		.i_adcdat  (i_adcdat),
		.i_adclrck (i_adclrck),
		.o_wr_stb  (wr_stb),
		.o_wr_addr (wr_addr),
		.o_wr_data (wr_data)
	);

	play_dsp #(
		.P_SAMPLE_W (P_SAMPLE_W),
		.P_ADDR_W   (P_ADDR_W)
	) u_dsp (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_cmd       (play_cmd),
		.i_cfg       (play_cfg),
		.i_end_addr  (end_addr),
		.i_daclrck   (i_daclrck),
		.i_rdata     (i_sram_rdata),
		.o_rd_addr   (rd_addr),
		.o_sample    (play_sample),
		.o_player_en (player_en),
		.o_end       (play_end)
	);

	i2s_tx #(
		.P_SAMPLE_W (P_SAMPLE_W)
	) u_tx (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_en      (player_en),
		.i_daclrck (i_daclrck),
		.i_sample  (play_sample),
		.o_dacdat  (o_dacdat)
	);

endmodule

// File: tb/sram_model.sv
module sram_model
	import audio_pkg::*;
#(
	parameter int P_ADDR_W = ADDR_W
) (
	input  logic [P_ADDR_W-1:0] i_addr,
	input  sample_t             i_wdata,
	input  logic                i_we_n,
	output sample_t             o_rdata
);
	timeunit 1ns;
	timeprecision 100ps;

	sample_t mem [0:(1<<P_ADDR_W)-1];

	// fill pattern from all address bits
	initial begin
		for (int a = 0; a < (1 << P_ADDR_W); a++)
			mem[a] = sample_t'(a[15:0] ^ {a[19:16], a[19:16], a[19:16], a[19:16]});
	end

	assign o_rdata = mem[i_addr]; // async read

	// strobe low for a whole cycle, take the bus once it has settled
	always @(negedge i_we_n) begin
		#1;
		if (!i_we_n)
			mem[i_addr] = i_wdata;
	end

endmodule

// File: tb/tb_audio.sv
module tb_audio
	import audio_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 3000; // cycles per wait
	localparam int K_REC   = 0;
	localparam int K_PLAY  = 1;
	localparam int K_PAUSE = 2;
	localparam int K_STOP  = 3;

	logic        clk;
	logic        rst_n;
	logic        rec;
	logic        play;
	logic        pause;
	logic        stop;
	logic [3:0]  speed;
	logic        fast;
	logic        inte;
	logic        lrclk;
	logic        adcdat;
	sample_t     sram_rdata;
	sram_req_t   sram;
	logic        dacdat;
	mode_e       mode;

	logic [15:0] tdata [0:63];
	logic [4:0]  phase;      // position inside the 32 cycle frame
	int          frame_cnt;
	logic        use_list;   // adc words from the data file or per frame
	int          adc_ptr;
	logic [15:0] adc_word;
	logic        dec_on;
	logic [15:0] dac_sr;
	logic [15:0] dac_words [$];
	logic [19:0] wr_addrs [$];
	logic [15:0] wr_datas [$];
	int          test_err;
	int          pass_cnt;
	int          fail_cnt;
	int          n_samp;

	audio_top dut (
		.i_clk(clk), .i_rst_n(rst_n), .i_rec(rec), .i_play(play), .i_pause(pause),
		.i_stop(stop), .i_speed(speed), .i_fast(fast), .i_inte(inte), .i_adcdat(adcdat),
		.i_adclrck(lrclk), .i_daclrck(lrclk), .i_sram_rdata(sram_rdata),
		.o_sram(sram), .o_dacdat(dacdat), .o_mode(mode)
	);

	sram_model #(.P_ADDR_W(ADDR_W)) u_sram (
		.i_addr(sram.addr), .i_wdata(sram.wdata), .i_we_n(sram.we_n), .o_rdata(sram_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// dac bits sit on the line in cycles 1 to 16 of the frame
	always @(negedge clk) begin
		if (phase >= 5'd1 && phase <= 5'd16) begin
			dac_sr = {dac_sr[14:0], dacdat};
			if (phase == 5'd16 && dec_on)
				dac_words.push_back(dac_sr);
		end
	end

	always @(negedge clk) begin
		if (rst_n && !sram.we_n) begin
			wr_addrs.push_back(sram.addr);
			wr_datas.push_back(sram.wdata);
		end
	end

	// inputs change 1 ns after the edge
	task tick();
		@(posedge clk);
		#1;
		phase = phase + 5'd1;
		if (phase == 5'd0) begin
			frame_cnt++;
			if (use_list) begin
				adc_word = (adc_ptr < n_samp) ? tdata[1 + adc_ptr] : 16'h0000;
				adc_ptr++;
			end else begin
				adc_word = 16'h5000 + 16'(frame_cnt);
			end
		end
		lrclk  = phase[4]; // low half is the left channel
		adcdat = phase[4] ? 1'b0 : adc_word[4'd15 - phase[3:0]];
	endtask

	task press(input int key);
		case (key)
			K_REC:   rec = 1'b1;
			K_PLAY:  play = 1'b1;
			K_PAUSE: pause = 1'b1;
			default: stop = 1'b1;
		endcase
		tick();
		rec   = 1'b0;
		play  = 1'b0;
		pause = 1'b0;
		stop  = 1'b0;
	endtask

	task report_mismatch(input string name, input int got, input int exp);
		$display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
		test_err++;
	endtask

	task report_timeout(input string what, input int limit);
		$display("%0t: %s did not happen within %0d cycles", $time, what, limit);
		test_err++;
	endtask

	task wait_phase(input logic [4:0] p);
		int n;
		n = 0;
		tick();
		while (phase != p && n < 64) begin
			tick();
			n++;
		end
		if (phase != p)
			report_timeout("frame position", 64);
	endtask

	task wait_mode(input mode_e m, input string what);
		int n;
		n = 0;
		while (mode != m && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (mode != m)
			report_timeout(what, TIMEOUT);
	endtask

	task wait_writes(input int count);
		int n;
		n = 0;
		while (wr_datas.size() < count && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (wr_datas.size() < count)
			report_timeout("sram write", TIMEOUT);
	endtask

	task wait_words(input int count);
		int n;
		n = 0;
		while (dac_words.size() < count && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (dac_words.size() < count)
			report_timeout("dac word", TIMEOUT);
	endtask

	task finish_test(input string name);
		if (test_err == 0) begin
			pass_cnt++;
			$display("test %-20s ok", name);
		end else begin
			fail_cnt++;
			$display("test %-20s failed with %0d errors", name, test_err);
		end
		test_err = 0;
	endtask

	task start_play();
		wait_phase(5'd20);
		press(K_PLAY);
		wait_phase(5'd17); // the next frame carries the first word
		dac_words.delete();
		dec_on = 1'b1;
	endtask

	task play_and_compare(input int base, output int next_base);
		int cnt;
		int i;
		speed = tdata[base][3:0];
		fast  = tdata[base + 1][0];
		inte  = tdata[base + 2][0];
		cnt   = int'(tdata[base + 3]);
		start_play();
		wait_mode(MODE_WAIT, "return to MODE_WAIT after playback");
		dec_on = 1'b0;
		if (dac_words.size() != cnt)
			report_mismatch("decoded word count", dac_words.size(), cnt);
		for (i = 0; i < cnt && i < dac_words.size(); i++) begin
			if (dac_words[i] != tdata[base + 4 + i])
				report_mismatch($sformatf("o_dacdat word %0d", i), dac_words[i],
					tdata[base + 4 + i]);
		end
		next_base = base + 4 + cnt;
	endtask

	initial begin
		int base;
		int n_tests;
		int k;
		int f_start;
		int f_pause;
		int f_resume;
		logic [15:0] exp_q [$];

		void'($urandom(20));
		$readmemh("tb/audio_testdata.txt", tdata);
		n_samp = int'(tdata[0]);
		{rst_n, rec, play, pause, stop, fast, inte, adcdat, dec_on} = '0;
		speed = 4'd1;
		lrclk = 1'b1;
		phase = 5'd31;
		frame_cnt = 0;
		use_list = 1'b1;
		adc_ptr = n_samp;
		adc_word = '0;
		dac_sr = '0;
		{test_err, pass_cnt, fail_cnt} = '0;
		repeat (10) tick();
		rst_n = 1'b1;
		tick();

		if (mode != MODE_IDLE)
			report_mismatch("o_mode", int'(mode), int'(MODE_IDLE));
		if (sram.we_n != 1'b1)
			report_mismatch("o_sram.we_n", sram.we_n, 1);
		if (dacdat != 1'b0)
			report_mismatch("o_dacdat", dacdat, 0);
		finish_test("reset");

		wr_addrs.delete();
		wr_datas.delete();
		wait_phase(5'd20);
		adc_ptr = 0;
		press(K_REC);
		wait_writes(n_samp);
		wait_phase(5'd20);
		press(K_STOP);
		if (mode != MODE_WAIT)
			report_mismatch("o_mode", int'(mode), int'(MODE_WAIT));
		if (wr_datas.size() != n_samp)
			report_mismatch("write count", wr_datas.size(), n_samp);
		for (int i = 0; i < n_samp && i < wr_datas.size(); i++) begin
			if (wr_addrs[i] != 20'(i))
				report_mismatch("o_sram.addr", wr_addrs[i], i);
			if (wr_datas[i] != tdata[1 + i])
				report_mismatch("o_sram.wdata", wr_datas[i], tdata[1 + i]);
		end
		finish_test("record");

		n_tests = int'(tdata[1 + n_samp]);
		base = 2 + n_samp;
		for (int t = 0; t < n_tests; t++) begin
			play_and_compare(base, base);
			finish_test($sformatf("playback %0d", t));
		end

		// frame numbered words make drops and repeats visible
		use_list = 1'b0;
		wr_addrs.delete();
		wr_datas.delete();
		wait_phase(5'd20);
		f_start = frame_cnt;
		press(K_REC);
		wait_writes(3);
		wait_phase(5'd8); // mid word
		f_pause = frame_cnt;
		press(K_PAUSE);
		if (mode != MODE_REC_PAUSE)
			report_mismatch("o_mode", int'(mode), int'(MODE_REC_PAUSE));
		k = int'($urandom % 4) + 1;
		repeat (k) wait_phase(5'd20);
		f_resume = frame_cnt;
		press(K_PAUSE);
		wait_writes(f_pause - f_start - 1 + 3);
		wait_phase(5'd20);
		press(K_STOP);
		if (mode != MODE_WAIT)
			report_mismatch("o_mode", int'(mode), int'(MODE_WAIT));
		for (int f = f_start + 1; f < f_pause; f++)
			exp_q.push_back(16'h5000 + 16'(f));
		for (int j = 1; j <= 3; j++)
			exp_q.push_back(16'h5000 + 16'(f_resume + j));
		if (wr_datas.size() != exp_q.size())
			report_mismatch("write count", wr_datas.size(), exp_q.size());
		for (int i = 0; i < exp_q.size() && i < wr_datas.size(); i++) begin
			if (wr_addrs[i] != 20'(i))
				report_mismatch("o_sram.addr", wr_addrs[i], i);
			if (wr_datas[i] != exp_q[i])
				report_mismatch("o_sram.wdata", wr_datas[i], exp_q[i]);
		end
		finish_test($sformatf("record pause %0d", k));

		speed = 4'd1;
		fast  = 1'b1;
		inte  = 1'b0;
		for (int r = 0; r < 2; r++) begin
			start_play();
			wait_words(2);
			wait_phase(5'd20);
			press(K_STOP);
			dec_on = 1'b0;
			wait_mode(MODE_WAIT, "stop during playback");
			for (int i = 0; i < 2 && i < dac_words.size() && i < exp_q.size(); i++) begin
				if (dac_words[i] != exp_q[i])
					report_mismatch($sformatf("o_dacdat word %0d", i), dac_words[i],
						exp_q[i]);
			end
		end
		finish_test("stop and restart");

		$display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: tb.f
common/audio_pkg.sv
source/audio_ctrl.sv
recorder/i2s_rx.sv
player/play_dsp.sv
player/i2s_tx.sv
source/audio_top.sv
tb/sram_model.sv
tb/tb_audio.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_audio
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f tb.f --Mdir $(BUILD_DIR) -o sim
	./$(BUILD_DIR)/sim | tee $(LOG)
	@! grep -q "STATUS: FAIL" $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/audio_testdata.txt
// sample count, then the samples
0006
0100 0301 FF00 0010 1235 F000
// number of playback tests
0004
// per test: speed, fast, inte, word count, expected dac words
0001 0001 0000 0006
0100 0301 FF00 0010 1235 F000
0003 0001 0000 0002
0100 0010
0002 0000 0000 000B
0100 0100 0301 0301 FF00 FF00 0010 0010 1235 1235 F000
0002 0000 0001 000B
0100 0200 0301 0101 FF00 FF88 0010 0922 1235 011B F000
